// File: common/btb_pkg.sv
package btb_pkg;

    // direct-mapped geometry with one entry per low EIP index
    localparam int BTB_ENTRIES = 64;
    localparam int INDEX_BITS  = 6;    // eip[5:0]
    localparam int TAG_BITS    = 26;   // eip[31:6]

    // fetch lines are 16 bytes, so a line address is eip[31:4]
    localparam int LINE_BITS   = 28;

    // one stored branch
    // the line pair is kept so a hit can steer both cache banks
    // without recomputing anything from the target
    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [31:0]          target_eip;
        logic [LINE_BITS-1:0] fip_e;    // even bank line
        logic [LINE_BITS-1:0] fip_o;    // odd bank line
    } btb_entry_t;

endpackage

// File: common/fetch_pkg.sv
package fetch_pkg;

    // first fetch after reset
    localparam logic [31:0] RESET_EIP = 32'h0000_fff0;

    // why the current fetch address was picked
    typedef enum logic [1:0] {
        FETCH_SEQ      = 2'd0,  // next 16-byte line
        FETCH_PREDICT  = 2'd1,  // taken from a btb hit
        FETCH_REDIRECT = 2'd2,  // writeback correction
        FETCH_RESET    = 2'd3   // reset vector
    } fetch_src_e;

    // taken branch reported by writeback
    typedef struct packed {
        logic [31:0]                   branch_eip;
        logic [31:0]                   target_eip;
        logic [btb_pkg::LINE_BITS-1:0] fip_e;
        logic [btb_pkg::LINE_BITS-1:0] fip_o;
    } btb_update_t;

    // what the cache side sees for the current fetch
    typedef struct packed {
        logic [31:0]                   eip;
        logic [btb_pkg::LINE_BITS-1:0] fip_e;
        logic [btb_pkg::LINE_BITS-1:0] fip_o;
        fetch_src_e                    src;
        logic                          btb_hit;  // lookup result for eip
    } fetch_bundle_t;

endpackage

// File: btb/btb_store.sv
`timescale 1ns/1ns

module btb_store (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             wr_en,
    input  logic [btb_pkg::INDEX_BITS-1:0]   wr_index,
    input  btb_pkg::btb_entry_t              wr_entry,
    input  logic [btb_pkg::INDEX_BITS-1:0]   rd_index,
    output logic                             rd_valid,
    output btb_pkg::btb_entry_t              rd_entry
);

    logic [btb_pkg::BTB_ENTRIES-1:0] valid;
    btb_pkg::btb_entry_t             entries [btb_pkg::BTB_ENTRIES];

    // valid bits are cleared on reset so nothing stale can hit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // every write replaces the whole entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // combinational read by index
    assign rd_valid = valid[rd_index];
    assign rd_entry = entries[rd_index];

endmodule

// File: btb/branch_target_buff.sv
`timescale 1ns/1ns

module branch_target_buff (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [31:0]                    lookup_eip,
    input  logic                           wr_en,
    input  fetch_pkg::btb_update_t         wr_data,
    output logic                           hit,
    output logic [31:0]                    target_eip,
    output logic [btb_pkg::LINE_BITS-1:0]  fip_e_target,
    output logic [btb_pkg::LINE_BITS-1:0]  fip_o_target
);

    logic [btb_pkg::INDEX_BITS-1:0] lookup_index;
    logic [btb_pkg::TAG_BITS-1:0]   lookup_tag;
    logic [btb_pkg::INDEX_BITS-1:0] wr_index;
    btb_pkg::btb_entry_t            wr_entry;
    logic                           rd_valid;
    btb_pkg::btb_entry_t            rd_entry;

    // index from the low bits, tag from everything above
    assign lookup_index = lookup_eip[btb_pkg::INDEX_BITS-1:0];
    assign lookup_tag   = lookup_eip[btb_pkg::INDEX_BITS +: btb_pkg::TAG_BITS];

    assign wr_index = wr_data.branch_eip[btb_pkg::INDEX_BITS-1:0];

    always_comb begin
        wr_entry.tag        = wr_data.branch_eip[btb_pkg::INDEX_BITS +: btb_pkg::TAG_BITS];
        wr_entry.target_eip = wr_data.target_eip;
        wr_entry.fip_e      = wr_data.fip_e;
        wr_entry.fip_o      = wr_data.fip_o;
    end

    btb_store store_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_index (lookup_index),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry)
    );

    // only the indexed entry can hit
    assign hit = rd_valid && (rd_entry.tag == lookup_tag);

    // stored fields go out on a miss too and the fetch pointer ignores them then
    assign target_eip   = rd_entry.target_eip;
    assign fip_e_target = rd_entry.fip_e;
    assign fip_o_target = rd_entry.fip_o;

    // an X on the write strobe would corrupt valid bits silently
    a_wr_en_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(wr_en)
    ) else $error("btb write enable is unknown");

endmodule

// File: verilog/btb_update_port.sv
`timescale 1ns/1ns

module btb_update_port (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    upd_req,
    input  fetch_pkg::btb_update_t  upd,
    output logic                    upd_ack,
    output logic                    wr_en,
    output fetch_pkg::btb_update_t  wr_data
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,   // waiting for req
        WRITE    = 2'd1,   // wr_en high and the entry written at the next edge
        ACK_WAIT = 2'd2    // ack high until req drops
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (upd_req) state_nxt = WRITE;
            WRITE:    state_nxt = ACK_WAIT;
            ACK_WAIT: if (!upd_req) state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture the request when it is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && upd_req) begin
            wr_data <= upd;
        end
    end

    assign wr_en   = (state == WRITE);
    assign upd_ack = (state == ACK_WAIT);  // rises on the write edge

    a_wr_en_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |=> !wr_en
    ) else $error("btb write lasted more than one cycle");

    // ack may only drop once writeback has released req
    a_ack_hold: assert property (
        @(posedge clk) disable iff (!arst_n) (upd_ack && upd_req) |=> upd_ack
    ) else $error("upd_ack fell while upd_req was high");

endmodule

// File: verilog/fetch_pointer.sv
`timescale 1ns/1ns

module fetch_pointer (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           fetch_ready,
    input  logic                           redirect_valid,
    input  logic [31:0]                    redirect_eip,
    input  logic                           btb_hit,
    input  logic [31:0]                    btb_target,
    input  logic [btb_pkg::LINE_BITS-1:0]  btb_fip_e,
    input  logic [btb_pkg::LINE_BITS-1:0]  btb_fip_o,
    output logic [31:0]                    lookup_eip,
    output fetch_pkg::fetch_bundle_t       fetch
);

    typedef struct packed {
        logic [btb_pkg::LINE_BITS-1:0] fip_e;
        logic [btb_pkg::LINE_BITS-1:0] fip_o;
    } line_pair_t;

    // the pair covers the line holding eip and the one after it,
    // sorted into the even and odd bank
    function automatic line_pair_t line_pair(input logic [31:0] eip);
        logic [btb_pkg::LINE_BITS-1:0] line;
        logic [btb_pkg::LINE_BITS-1:0] line_next;
        line_pair_t                    pair;
        line      = eip[31 -: btb_pkg::LINE_BITS];
        line_next = line + 1'b1;
        if (line[0]) begin
            pair.fip_e = line_next;
            pair.fip_o = line;
        end else begin
            pair.fip_e = line;
            pair.fip_o = line_next;
        end
        return pair;
    endfunction

    logic [31:0]           cur_eip;
    line_pair_t            cur_lines;
    fetch_pkg::fetch_src_e cur_src;

    logic [31:0]           seq_eip;
    logic [31:0]           nxt_eip;
    line_pair_t            nxt_lines;
    fetch_pkg::fetch_src_e nxt_src;
    logic                  load;

    assign seq_eip = {cur_eip[31 -: btb_pkg::LINE_BITS] + 1'b1, 4'h0};  // next 16B line

    // redirect first, then prediction, then fall through
    always_comb begin
        if (redirect_valid) begin
            nxt_eip   = redirect_eip;
            nxt_lines = line_pair(redirect_eip);
            nxt_src   = fetch_pkg::FETCH_REDIRECT;
        end else if (btb_hit) begin
            nxt_eip         = btb_target;
            nxt_lines.fip_e = btb_fip_e;
            nxt_lines.fip_o = btb_fip_o;
            nxt_src         = fetch_pkg::FETCH_PREDICT;
        end else begin
            nxt_eip   = seq_eip;
            nxt_lines = line_pair(seq_eip);
            nxt_src   = fetch_pkg::FETCH_SEQ;
        end
    end

    assign load = fetch_ready || redirect_valid;  // a redirect is never stalled

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_eip   <= fetch_pkg::RESET_EIP;
            cur_lines <= line_pair(fetch_pkg::RESET_EIP);
            cur_src   <= fetch_pkg::FETCH_RESET;
        end else if (load) begin
            cur_eip   <= nxt_eip;
            cur_lines <= nxt_lines;
            cur_src   <= nxt_src;
        end
    end

    assign lookup_eip = cur_eip;

    always_comb begin
        fetch.eip     = cur_eip;
        fetch.fip_e   = cur_lines.fip_e;
        fetch.fip_o   = cur_lines.fip_o;
        fetch.src     = cur_src;
        fetch.btb_hit = btb_hit;  // hit seen for the eip being fetched now
    end

    a_seq_line_parity: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fetch.src == fetch_pkg::FETCH_SEQ) |-> (!fetch.fip_e[0] && fetch.fip_o[0])
    ) else $error("sequential fetch has a wrong line pair");

endmodule

// File: verilog/fetch_predict_top.sv
`timescale 1ns/1ns

module fetch_predict_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      fetch_ready,
    input  logic                      redirect_valid,
    input  logic [31:0]               redirect_eip,
    input  logic                      upd_req,
    input  fetch_pkg::btb_update_t    upd,
    output logic                      upd_ack,
    output fetch_pkg::fetch_bundle_t  fetch
);

    logic                          btb_wr_en;
    fetch_pkg::btb_update_t        btb_wr_data;
    logic [31:0]                   lookup_eip;
    logic                          btb_hit;
    logic [31:0]                   btb_target;
    logic [btb_pkg::LINE_BITS-1:0] btb_fip_e;
    logic [btb_pkg::LINE_BITS-1:0] btb_fip_o;

    // writeback handshake into a single write strobe
    btb_update_port update_port_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .upd_req (upd_req),
        .upd     (upd),
        .upd_ack (upd_ack),
        .wr_en   (btb_wr_en),
        .wr_data (btb_wr_data)
    );

    branch_target_buff btb_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_eip   (lookup_eip),
        .wr_en        (btb_wr_en),
        .wr_data      (btb_wr_data),
        .hit          (btb_hit),
        .target_eip   (btb_target),
        .fip_e_target (btb_fip_e),
        .fip_o_target (btb_fip_o)
    );

    fetch_pointer fetch_pointer_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_ready    (fetch_ready),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .btb_fip_e      (btb_fip_e),
        .btb_fip_o      (btb_fip_o),
        .lookup_eip     (lookup_eip),
        .fetch          (fetch)
    );

endmodule

// File: verification/tb_fetch_predict.sv
`timescale 1ns/1ns

module tb_fetch_predict;

    typedef enum logic [1:0] {
        STEP_RUN,       // fetch_ready high
        STEP_STALL,     // fetch_ready low
        STEP_REDIRECT,  // one redirect pulse then plain cycles
        STEP_UPDATE     // btb write through the handshake
    } step_kind_e;

    typedef struct packed {
        step_kind_e            kind;
        logic [31:0]           a;        // redirect eip or branch eip
        logic [31:0]           b;        // branch target
        logic                  ready;
        logic [7:0]            cycles;   // updates use it as extra req-high cycles after ack
        logic [31:0]           exp_eip;
        fetch_pkg::fetch_src_e exp_src;
    } step_t;

    typedef enum logic [1:0] {WB_IDLE, WB_WRITE, WB_ACK} port_phase_e;

    localparam int NUM_STEPS     = 18;
    localparam int RANDOM_CYCLES = 200;
    localparam int ACK_LIMIT     = 8;

    localparam fetch_pkg::fetch_src_e SEQ   = fetch_pkg::FETCH_SEQ;
    localparam fetch_pkg::fetch_src_e PRED  = fetch_pkg::FETCH_PREDICT;
    localparam fetch_pkg::fetch_src_e REDIR = fetch_pkg::FETCH_REDIRECT;

    step_t steps [NUM_STEPS] = '{
        '{STEP_RUN,      32'h00000000, 32'h00000000, 1'b1, 8'd3, 32'h00010020, SEQ},
        '{STEP_UPDATE,   32'h00012344, 32'h00020008, 1'b0, 8'd0, 32'h00010020, SEQ},
        '{STEP_REDIRECT, 32'h00012344, 32'h00000000, 1'b1, 8'd1, 32'h00012344, REDIR},
        '{STEP_RUN,      32'h00000000, 32'h00000000, 1'b1, 8'd1, 32'h00020008, PRED},
        '{STEP_RUN,      32'h00000000, 32'h00000000, 1'b1, 8'd1, 32'h00020010, SEQ},
        // same index as 0x12344 with another tag
        '{STEP_REDIRECT, 32'h00030044, 32'h00000000, 1'b1, 8'd2, 32'h00030050, SEQ},
        '{STEP_UPDATE,   32'h00030044, 32'h00040100, 1'b0, 8'd0, 32'h00030050, SEQ},
        '{STEP_REDIRECT, 32'h00012344, 32'h00000000, 1'b1, 8'd2, 32'h00012350, SEQ},
        '{STEP_REDIRECT, 32'h00030044, 32'h00000000, 1'b1, 8'd2, 32'h00040100, PRED},
        '{STEP_STALL,    32'h00000000, 32'h00000000, 1'b0, 8'd4, 32'h00040100, PRED},
        // second redirect lands while 0x30044 hits
        '{STEP_REDIRECT, 32'h00030044, 32'h00000000, 1'b1, 8'd1, 32'h00030044, REDIR},
        '{STEP_REDIRECT, 32'h00050000, 32'h00000000, 1'b1, 8'd1, 32'h00050000, REDIR},
        '{STEP_REDIRECT, 32'h00060000, 32'h00000000, 1'b0, 8'd3, 32'h00060000, REDIR},
        '{STEP_UPDATE,   32'h00070010, 32'h00080000, 1'b0, 8'd6, 32'h00060000, REDIR},
        '{STEP_REDIRECT, 32'h00070010, 32'h00000000, 1'b1, 8'd2, 32'h00080000, PRED},
        '{STEP_REDIRECT, 32'h00070110, 32'h00000000, 1'b1, 8'd2, 32'h00070120, SEQ},
        '{STEP_RUN,      32'h00000000, 32'h00000000, 1'b1, 8'd2, 32'h00070140, SEQ},
        '{STEP_STALL,    32'h00000000, 32'h00000000, 1'b0, 8'd2, 32'h00070140, SEQ}
    };

    logic                     clk;
    logic                     arst_n;
    logic                     fetch_ready;
    logic                     redirect_valid;
    logic [31:0]              redirect_eip;
    logic                     upd_req;
    fetch_pkg::btb_update_t   upd;
    logic                     upd_ack;
    fetch_pkg::fetch_bundle_t fetch;

    // reference model of the btb and the expected fetch
    logic                model_valid [btb_pkg::BTB_ENTRIES];
    btb_pkg::btb_entry_t model_entry [btb_pkg::BTB_ENTRIES];
    logic [31:0]            exp_eip;
    logic [27:0]            exp_fe;
    logic [27:0]            exp_fo;
    fetch_pkg::fetch_src_e  exp_src;
    port_phase_e            port_phase;
    fetch_pkg::btb_update_t port_latch;

    logic [31:0] rng_state = 32'h2ec7;
    string       test_name = "startup";
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    fetch_predict_top dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_ready    (fetch_ready),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .upd_req        (upd_req),
        .upd            (upd),
        .upd_ack        (upd_ack),
        .fetch          (fetch)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error in %s: expected %h actual %h", what, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // {fip_e, fip_o} for the line of eip and the one after it
    function automatic logic [55:0] line_pair(input logic [31:0] eip);
        logic [27:0] line;
        line = eip[31:4];
        return {line + {27'd0, line[0]}, line + {27'd0, ~line[0]}};
    endfunction

    function automatic logic model_hit(input logic [31:0] eip);
        return model_valid[eip[5:0]] && (model_entry[eip[5:0]].tag == eip[31:6]);
    endfunction

    function automatic void model_write(input fetch_pkg::btb_update_t u);
        model_valid[u.branch_eip[5:0]] = 1'b1;
        model_entry[u.branch_eip[5:0]] = '{u.branch_eip[31:6], u.target_eip, u.fip_e, u.fip_o};
    endfunction

    task automatic compare_outputs();
        check_value({test_name, " eip"}, exp_eip, fetch.eip);
        check_value({test_name, " fip_e"}, 32'(exp_fe), 32'(fetch.fip_e));
        check_value({test_name, " fip_o"}, 32'(exp_fo), 32'(fetch.fip_o));
        check_value({test_name, " src"}, 32'(exp_src), 32'(fetch.src));
        check_value({test_name, " btb_hit"}, 32'(model_hit(exp_eip)), 32'(fetch.btb_hit));
        check_value({test_name, " upd_ack"}, 32'(port_phase == WB_ACK), 32'(upd_ack));
    endtask

    // predict the next edge, let it happen and compare at the falling edge
    task automatic tick();
        logic [55:0]            pair;
        logic                   hit_now;
        logic                   req_now;
        fetch_pkg::btb_update_t upd_now;
        hit_now = model_hit(exp_eip);
        req_now = upd_req;
        upd_now = upd;
        if (redirect_valid) begin
            pair    = line_pair(redirect_eip);
            exp_eip = redirect_eip;
            exp_fe  = pair[55:28];
            exp_fo  = pair[27:0];
            exp_src = fetch_pkg::FETCH_REDIRECT;
        end else if (fetch_ready && hit_now) begin
            exp_fe  = model_entry[exp_eip[5:0]].fip_e;
            exp_fo  = model_entry[exp_eip[5:0]].fip_o;
            exp_eip = model_entry[exp_eip[5:0]].target_eip;
            exp_src = fetch_pkg::FETCH_PREDICT;
        end else if (fetch_ready) begin
            exp_eip = {exp_eip[31:4], 4'h0} + 32'd16;
            pair    = line_pair(exp_eip);
            exp_fe  = pair[55:28];
            exp_fo  = pair[27:0];
            exp_src = fetch_pkg::FETCH_SEQ;
        end
        @(posedge clk);
        case (port_phase)
            WB_IDLE: begin
                if (req_now) begin
                    port_latch = upd_now;
                    port_phase = WB_WRITE;
                end
            end
            WB_WRITE: begin
                model_write(port_latch);  // lookups already used the old entry this edge
                port_phase = WB_ACK;
            end
            default: begin
                if (!req_now) port_phase = WB_IDLE;
            end
        endcase
        @(negedge clk);
        compare_outputs();
    endtask

    // writeback side of the four-phase handshake
    task automatic write_btb(input logic [31:0] branch, input logic [31:0] target,
                             input int hold);
        logic [55:0] pair;
        int          waited;
        pair           = line_pair(target);
        upd.branch_eip = branch;
        upd.target_eip = target;
        upd.fip_e      = pair[55:28];
        upd.fip_o      = pair[27:0];
        upd_req        = 1'b1;
        waited         = 0;
        while (!upd_ack && waited < ACK_LIMIT) begin
            tick();
            waited++;
        end
        if (!upd_ack) abort_run("upd_ack did not rise within 8 cycles of upd_req");
        // a repeated write would store this aliasing branch instead
        if (hold > 0) begin
            upd.branch_eip = branch ^ 32'h100;
            upd.target_eip = target + 32'h40;
            repeat (hold) tick();
        end
        upd_req = 1'b0;
        waited  = 0;
        while (upd_ack && waited < ACK_LIMIT) begin
            tick();
            waited++;
        end
        if (upd_ack) abort_run("upd_ack stayed high for 8 cycles after upd_req dropped");
    endtask

    task automatic apply_step(input step_t s);
        fetch_ready = s.ready;
        case (s.kind)
            STEP_REDIRECT: begin
                redirect_valid = 1'b1;
                redirect_eip   = s.a;
                tick();
                redirect_valid = 1'b0;
                repeat (int'(s.cycles) - 1) tick();
            end
            STEP_UPDATE: write_btb(s.a, s.b, int'(s.cycles));
            default:     repeat (int'(s.cycles)) tick();
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run("simulation ran past its cycle limit without finishing");
        end
    end

    initial begin
        logic [55:0] pair;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        int          limit;
        limit = 16 + RANDOM_CYCLES + 100;  // reset, random phase, margin
        foreach (steps[i]) begin
            limit += int'(steps[i].cycles) + ((steps[i].kind == STEP_UPDATE) ? 20 : 0);
        end
        cycle_limit    = limit;
        arst_n         = 1'b0;
        fetch_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_eip   = '0;
        upd_req        = 1'b0;
        upd            = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        foreach (model_valid[i]) model_valid[i] = 1'b0;
        pair       = line_pair(fetch_pkg::RESET_EIP);
        exp_eip    = fetch_pkg::RESET_EIP;
        exp_fe     = pair[55:28];
        exp_fo     = pair[27:0];
        exp_src    = fetch_pkg::FETCH_RESET;
        port_phase = WB_IDLE;
        test_name  = "reset";
        compare_outputs();

        for (int i = 0; i < NUM_STEPS; i++) begin
            test_name = $sformatf("step %0d", i);
            apply_step(steps[i]);
            check_value({test_name, " table eip"}, steps[i].exp_eip, fetch.eip);
            check_value({test_name, " table src"}, 32'(steps[i].exp_src), 32'(fetch.src));
        end

        // small address window so random branches alias and hit often
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r              = next_random();
            fetch_ready    = (r[1:0] != 2'b00);
            redirect_valid = (r[4:2] == 3'b000);
            redirect_eip   = {24'h000a00, r[15:8]};
            if (!upd_req && !upd_ack && r[7:5] == 3'b000) begin
                r2             = next_random();
                r3             = next_random();
                upd.branch_eip = {24'h000a00, r2[7:0]};
                upd.target_eip = {24'h000a00, r2[15:8]};
                upd.fip_e      = r3[27:0];
                upd.fip_o      = r2[31:4];
                upd_req        = 1'b1;
            end else if (upd_req && upd_ack) begin
                upd_req = 1'b0;
            end
            test_name = $sformatf("random cycle %0d", n);
            tick();
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: all.f
common/btb_pkg.sv
common/fetch_pkg.sv
btb/btb_store.sv
btb/branch_target_buff.sv
verilog/btb_update_port.sv
verilog/fetch_pointer.sv
verilog/fetch_predict_top.sv
verification/tb_fetch_predict.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the fetch prediction testbench with Verilator.
# Exit status is 0 only when the simulation log reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_predict \
    -f all.f \
    -Mdir obj_dir \
    -o sim_fetch_predict > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/sim_fetch_predict > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
